// ==== mpu_case_pkg.sv ====
// Shared definitions for the card-status block
// Typedefs for the widths that carry a meaning
// Card identity field positions and expected board constants
// Configuration feedback bit positions and the read register map
package mpu_case_pkg;

    // ------------------------------------------------------------
    // Widths and types
    // ------------------------------------------------------------
    localparam int NUM_CHANNELS = 16;

    typedef logic [31:0]             card_id_t;
    typedef logic [15:0]             version_t;
    typedef logic [3:0]              slot_num_t;
    typedef logic [7:0]              sta_num_t;
    typedef logic [2:0]              box_num_t;
    typedef logic [4:0]              board_type_t;
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;
    typedef logic [8:0]              reg_addr_t;
    typedef logic [15:0]             reg_data_t;
    typedef logic [7:0]              cfg_flags_t;

    // ------------------------------------------------------------
    // Card identity word layout
    // ------------------------------------------------------------
    localparam int SLOT_LSB = 0;
    localparam int BOX_LSB  = 5;
    localparam int STA_LSB  = 8;
    localparam int TYPE_LSB = 18;

    localparam board_type_t MPU_BOARD_TYPE   = 5'h05;
    localparam version_t    EXPECTED_VERSION = 16'h0100;

    // Feedback byte, bit 0 unused
    localparam int FB_TYPE    = 1;
    localparam int FB_HR      = 2;
    localparam int FB_VERSION = 3;
    localparam int FB_SLOT    = 4;
    localparam int FB_BOX     = 5;
    localparam int FB_STA     = 6;
    localparam int FB_WR_OK   = 7;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam reg_addr_t ADDR_CFG    = 9'd0;
    localparam reg_addr_t ADDR_SLINK  = 9'd1;
    localparam reg_addr_t ADDR_ENABLE = 9'd2;

endpackage

// ==== case_sync_if.sv ====
// Bundle of retimed configuration and presence inputs
// One source (input retiming), read by both checkers
`timescale 1ns/1ps

interface case_sync_if import mpu_case_pkg::*; ();

    // Backplane straps, two stages
    slot_num_t  slot_num;
    sta_num_t   sta_num;
    box_num_t   box_num;
    chan_mask_t online;

    // Configuration words, one stage
    card_id_t   card_id;
    version_t   code_version;
    chan_mask_t enable_slot;

    modport src (
        output slot_num, sta_num, box_num, online,
        output card_id, code_version, enable_slot
    );

    modport dst (
        input  slot_num, sta_num, box_num, online,
        input  card_id, code_version, enable_slot
    );

endinterface

// ==== case_input_sync.sv ====
// Input retiming for straps, presence and configuration words
// Drives the source side of the sync bundle
`timescale 1ns/1ps

module case_input_sync
    import mpu_case_pkg::*;
(
    input  logic        clk_150m,
    input  logic        rst_150m,
    input  slot_num_t   slot_num,
    input  sta_num_t    sta_num,
    input  box_num_t    box_num,
    input  chan_mask_t  online,
    input  card_id_t    card_id,
    input  version_t    code_version,
    input  chan_mask_t  enable_slot,
    case_sync_if.src    sync
);

    // First stage of the asynchronous straps
    slot_num_t  slot_meta;
    sta_num_t   sta_meta;
    box_num_t   box_meta;
    chan_mask_t online_meta;

    // ------------------------------------------------------------
    // Two stages for straps and presence
    // ------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            slot_meta     <= '0;
            sta_meta      <= '0;
            box_meta      <= '0;
            online_meta   <= '0;
            sync.slot_num <= '0;
            sync.sta_num  <= '0;
            sync.box_num  <= '0;
            sync.online   <= '0;
        end else begin
            slot_meta     <= slot_num;
            sta_meta      <= sta_num;
            box_meta      <= box_num;
            online_meta   <= online;
            sync.slot_num <= slot_meta;
            sync.sta_num  <= sta_meta;
            sync.box_num  <= box_meta;
            sync.online   <= online_meta;
        end
    end

    // Configuration words are quasi-static, one stage is enough
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            sync.card_id      <= '0;
            sync.code_version <= '0;
            sync.enable_slot  <= '0;
        end else begin
            sync.card_id      <= card_id;
            sync.code_version <= code_version;
            sync.enable_slot  <= enable_slot;
        end
    end

endmodule

// ==== cfg_check.sv ====
// Check-interval timer and configuration mismatch flags
// Compares card identity fields against straps and expected constants
// Produces the feedback byte and the summary self-error
`timescale 1ns/1ps

module cfg_check
    import mpu_case_pkg::*;
#(
    parameter int unsigned CHECK_PERIOD = 62500000
) (
    input  logic        clk_150m,
    input  logic        rst_150m,
    case_sync_if.dst    sync,
    input  logic        cfg_wr_ok,
    output cfg_flags_t  cfg_flags,
    output logic        self_cfg_err
);

    localparam int               CNT_W     = $clog2(CHECK_PERIOD + 1);
    localparam logic [CNT_W-1:0] PERIOD_LD = CNT_W'(CHECK_PERIOD);

    logic [CNT_W-1:0] check_cnt;
    logic             check_tick;

    // Fields pulled out of the card identity word
    slot_num_t   id_slot;
    box_num_t    id_box;
    sta_num_t    id_sta;
    board_type_t id_type;

    logic slot_fb;
    logic box_fb;
    logic sta_fb;
    logic type_fb;
    logic ver_fb;

    assign id_slot = sync.card_id[SLOT_LSB +: $bits(slot_num_t)];
    assign id_box  = sync.card_id[BOX_LSB  +: $bits(box_num_t)];
    assign id_sta  = sync.card_id[STA_LSB  +: $bits(sta_num_t)];
    assign id_type = sync.card_id[TYPE_LSB +: $bits(board_type_t)];

    // ------------------------------------------------------------
    // Check interval, tick is one cycle after zero
    // ------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            check_cnt  <= '0;
            check_tick <= 1'b0;
        end else begin
            check_tick <= (check_cnt == '0);
            if (check_cnt == '0)
                check_cnt <= PERIOD_LD;
            else
                check_cnt <= check_cnt - 1'b1;
        end
    end

    // Mismatch flags, held between ticks
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            slot_fb <= 1'b0;
            box_fb  <= 1'b0;
            sta_fb  <= 1'b0;
            type_fb <= 1'b0;
            ver_fb  <= 1'b0;
        end else if (check_tick) begin
            slot_fb <= (id_slot != sync.slot_num);
            box_fb  <= (id_box != sync.box_num);
            sta_fb  <= (id_sta != sync.sta_num);
            type_fb <= (id_type != MPU_BOARD_TYPE);
            ver_fb  <= (sync.code_version != EXPECTED_VERSION);
        end
    end

    // ------------------------------------------------------------
    // Feedback byte
    // ------------------------------------------------------------
    always_comb begin
        cfg_flags             = '0;
        cfg_flags[FB_TYPE]    = type_fb;
        cfg_flags[FB_HR]      = 1'b0;   // no hot redundancy on this board
        cfg_flags[FB_VERSION] = ver_fb;
        cfg_flags[FB_SLOT]    = slot_fb;
        cfg_flags[FB_BOX]     = box_fb;
        cfg_flags[FB_STA]     = sta_fb;
        cfg_flags[FB_WR_OK]   = cfg_wr_ok;
    end

    // Any mismatch, write-ok excluded
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m)
            self_cfg_err <= 1'b0;
        else
            self_cfg_err <= |cfg_flags[FB_STA:0];
    end

endmodule

// ==== slot_monitor.sv ====
// Per-channel card presence and dwell timing
// Enable feedback against the configured enable mask
// Link-error synchronizer, masked by the enable mask
`timescale 1ns/1ps

module slot_monitor
    import mpu_case_pkg::*;
#(
    parameter int unsigned SLOT_DWELL = 125000000
) (
    input  logic        clk_150m,
    input  logic        rst_150m,
    case_sync_if.dst    sync,
    input  logic        rd_sel,
    input  chan_mask_t  sta_dval,
    input  chan_mask_t  chn_slink_err,
    output chan_mask_t  enable_fb,
    output chan_mask_t  slink_err
);

    localparam int                 DWELL_W   = $clog2(SLOT_DWELL + 1);
    localparam logic [DWELL_W-1:0] DWELL_MAX = DWELL_W'(SLOT_DWELL);

    chan_mask_t dwell_done;
    chan_mask_t slink_meta;
    chan_mask_t slink_sync;

    // ------------------------------------------------------------
    // Presence and dwell per channel
    // ------------------------------------------------------------
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        logic               seen;
        logic [DWELL_W-1:0] dwell_cnt;

        // Card has reported status since it came online
        always_ff @(posedge clk_150m or negedge rst_150m) begin
            if (!rst_150m)
                seen <= 1'b0;
            else if (!sync.online[i])
                seen <= 1'b0;
            else if (sta_dval[i])
                seen <= 1'b1;
        end

        // Saturates at the dwell limit
        always_ff @(posedge clk_150m or negedge rst_150m) begin
            if (!rst_150m)
                dwell_cnt <= '0;
            else if (!seen)
                dwell_cnt <= '0;
            else if (dwell_cnt != DWELL_MAX)
                dwell_cnt <= dwell_cnt + 1'b1;
        end

        assign dwell_done[i] = (dwell_cnt == DWELL_MAX);
    end

    // One where the configured enable disagrees with a settled card
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m)
            enable_fb <= '0;
        else if (!rd_sel)
            enable_fb <= sync.enable_slot ^ (sync.online & dwell_done);
    end

    // ------------------------------------------------------------
    // Link errors
    // ------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            slink_meta <= '0;
            slink_sync <= '0;
        end else begin
            slink_meta <= chn_slink_err;
            slink_sync <= slink_meta;
        end
    end

    // Frozen during a read so the snapshot stays consistent
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m)
            slink_err <= '0;
        else if (!rd_sel)
            slink_err <= slink_sync & sync.enable_slot;
    end

endmodule

// ==== status_regfile.sv ====
// Held bus-error flag and the registered read decode
// rd_data follows rd_addr one cycle later while rd_sel is high
`timescale 1ns/1ps

module status_regfile
    import mpu_case_pkg::*;
(
    input  logic        clk_150m,
    input  logic        rst_150m,
    input  logic        rd_sel,
    input  reg_addr_t   rd_addr,
    input  logic        emif_err,
    input  cfg_flags_t  cfg_flags,
    input  chan_mask_t  enable_fb,
    input  chan_mask_t  slink_err,
    output reg_data_t   rd_data
);

    logic emif_err_hold;

    // Bus error sampled only between reads
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m)
            emif_err_hold <= 1'b0;
        else if (!rd_sel)
            emif_err_hold <= emif_err;
    end

    // ------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------
    always_ff @(posedge clk_150m or negedge rst_150m) begin
        if (!rst_150m) begin
            rd_data <= '0;
        end else if (rd_sel) begin
            case (rd_addr)
                ADDR_CFG:
                    rd_data <= {7'h00, emif_err_hold, cfg_flags};
                // Low byte of the error vector goes out in the high byte
                ADDR_SLINK:
                    rd_data <= {slink_err[7:0], slink_err[15:8]};
                ADDR_ENABLE:
                    rd_data <= enable_fb;
                default:
                    rd_data <= '0;
            endcase
        end else begin
            rd_data <= '0;
        end
    end

endmodule

// ==== mpu_case_status.sv ====
// Card-status block for the main processor board
// Input retiming, configuration check, slot monitor, read port
`timescale 1ns/1ps

module mpu_case_status
    import mpu_case_pkg::*;
#(
    parameter int unsigned CHECK_PERIOD = 62500000,
    parameter int unsigned SLOT_DWELL   = 125000000
) (
    input  logic        clk_150m,
    input  logic        rst_150m,

    // Processor read port
    input  logic        rd_sel,
    input  reg_addr_t   rd_addr,
    output reg_data_t   rd_data,

    // Board configuration
    input  card_id_t    card_id,
    input  version_t    code_version,
    input  chan_mask_t  enable_slot,
    input  slot_num_t   slot_num,
    input  sta_num_t    sta_num,
    input  box_num_t    box_num,
    input  logic        emif_err,
    input  logic        cfg_wr_ok,
    output logic        self_cfg_err,

    // Per-channel card status
    input  chan_mask_t  online,
    input  chan_mask_t  sta_dval,
    input  chan_mask_t  chn_slink_err
);

    cfg_flags_t cfg_flags;
    chan_mask_t enable_fb;
    chan_mask_t slink_err;

    case_sync_if sync_if ();

    // ------------------------------------------------------------
    // Retiming and checks
    // ------------------------------------------------------------
    case_input_sync case_input_sync_inst (
        .clk_150m     (clk_150m),
        .rst_150m     (rst_150m),
        .slot_num     (slot_num),
        .sta_num      (sta_num),
        .box_num      (box_num),
        .online       (online),
        .card_id      (card_id),
        .code_version (code_version),
        .enable_slot  (enable_slot),
        .sync         (sync_if.src)
    );

    cfg_check #(
        .CHECK_PERIOD (CHECK_PERIOD)
    ) cfg_check_inst (
        .clk_150m     (clk_150m),
        .rst_150m     (rst_150m),
        .sync         (sync_if.dst),
        .cfg_wr_ok    (cfg_wr_ok),
        .cfg_flags    (cfg_flags),
        .self_cfg_err (self_cfg_err)
    );

    slot_monitor #(
        .SLOT_DWELL   (SLOT_DWELL)
    ) slot_monitor_inst (
        .clk_150m      (clk_150m),
        .rst_150m      (rst_150m),
        .sync          (sync_if.dst),
        .rd_sel        (rd_sel),
        .sta_dval      (sta_dval),
        .chn_slink_err (chn_slink_err),
        .enable_fb     (enable_fb),
        .slink_err     (slink_err)
    );

    // Register read port
    status_regfile status_regfile_inst (
        .clk_150m  (clk_150m),
        .rst_150m  (rst_150m),
        .rd_sel    (rd_sel),
        .rd_addr   (rd_addr),
        .emif_err  (emif_err),
        .cfg_flags (cfg_flags),
        .enable_fb (enable_fb),
        .slink_err (slink_err),
        .rd_data   (rd_data)
    );

endmodule

// ==== mpu_case_checker.sv ====
// Bound assertions on the card-status top level
// Idle read data, summary self-error and known read data
`timescale 1ns/1ps

module mpu_case_checker
    import mpu_case_pkg::*;
(
    input  logic        clk_150m,
    input  logic        rst_150m,
    input  logic        rd_sel,
    input  reg_data_t   rd_data,
    input  cfg_flags_t  cfg_flags,
    input  logic        self_cfg_err
);

    // Read data falls back to zero one cycle after a read
    idle_read_zero: assert property (
        @(posedge clk_150m) disable iff (!rst_150m)
        !rd_sel |=> (rd_data == '0)
    ) else $error("rd_data not zero one cycle after rd_sel low");

    // Two clean cycles of flags leave no summary error
    clean_flags_no_err: assert property (
        @(posedge clk_150m) disable iff (!rst_150m)
        (cfg_flags[FB_STA:0] == '0) ##1 (cfg_flags[FB_STA:0] == '0) |-> !self_cfg_err
    ) else $error("self_cfg_err high with clean configuration flags");

    rd_data_known: assert property (
        @(posedge clk_150m) disable iff (!rst_150m)
        !$isunknown(rd_data)
    ) else $error("rd_data has unknown bits");

endmodule

bind mpu_case_status mpu_case_checker mpu_case_checker_inst (
    .clk_150m     (clk_150m),
    .rst_150m     (rst_150m),
    .rd_sel       (rd_sel),
    .rd_data      (rd_data),
    .cfg_flags    (cfg_flags),
    .self_cfg_err (self_cfg_err)
);

// ==== tb_mpu_case_status.sv ====
// Testbench for the card-status block
// Reads stimulus and expected register words from the pattern file
// Polls the read port until the words settle and checks idle reads
`timescale 1ns/1ps

module tb_mpu_case_status
    import mpu_case_pkg::*;
();

    localparam int unsigned CHECK_PERIOD = 20;
    localparam int unsigned SLOT_DWELL   = 16;

    // Poll rounds covering three check periods at six cycles per round
    localparam int POLL_TRIES = (3 * (CHECK_PERIOD + 1) + 5) / 6;
    localparam int NUM_FIELDS = 15;

    // Column positions in a pattern line
    localparam int F_TEST   = 0;
    localparam int F_CARD   = 1;
    localparam int F_VER    = 2;
    localparam int F_SLOT   = 3;
    localparam int F_STA    = 4;
    localparam int F_BOX    = 5;
    localparam int F_EN     = 6;
    localparam int F_ONLINE = 7;
    localparam int F_DVAL   = 8;
    localparam int F_SLINK  = 9;
    localparam int F_WR_OK  = 10;
    localparam int F_EMIF   = 11;
    localparam int F_EXP0   = 12;
    localparam int F_EXP1   = 13;
    localparam int F_EXP2   = 14;

    logic        clk_150m = 1'b0;
    logic        rst_150m;
    logic        rd_sel;
    reg_addr_t   rd_addr;
    reg_data_t   rd_data;
    card_id_t    card_id;
    version_t    code_version;
    chan_mask_t  enable_slot;
    slot_num_t   slot_num;
    sta_num_t    sta_num;
    box_num_t    box_num;
    logic        emif_err;
    logic        cfg_wr_ok;
    logic        self_cfg_err;
    chan_mask_t  online;
    chan_mask_t  sta_dval;
    chan_mask_t  chn_slink_err;

    logic [31:0] field [NUM_FIELDS];
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          setup_errors = 0;

    always #2 clk_150m = ~clk_150m;

    mpu_case_status #(
        .CHECK_PERIOD (CHECK_PERIOD),
        .SLOT_DWELL   (SLOT_DWELL)
    ) mpu_case_status_inst (
        .clk_150m      (clk_150m),
        .rst_150m      (rst_150m),
        .rd_sel        (rd_sel),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .card_id       (card_id),
        .code_version  (code_version),
        .enable_slot   (enable_slot),
        .slot_num      (slot_num),
        .sta_num       (sta_num),
        .box_num       (box_num),
        .emif_err      (emif_err),
        .cfg_wr_ok     (cfg_wr_ok),
        .self_cfg_err  (self_cfg_err),
        .online        (online),
        .sta_dval      (sta_dval),
        .chn_slink_err (chn_slink_err)
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic compare_word(input string name, input reg_data_t expected,
                                input reg_data_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected 0x%h got 0x%h", name, expected, actual);
            test_errors++;
        end
    endtask

    // One-cycle read sampled at the falling edge
    task automatic read_word(input reg_addr_t addr, output reg_data_t value);
        @(posedge clk_150m);
        rd_sel  <= 1'b1;
        rd_addr <= addr;
        @(posedge clk_150m);
        rd_sel  <= 1'b0;
        @(negedge clk_150m);
        value = rd_data;
    endtask

    task automatic apply_pattern();
        // All cards offline first so seen flags and dwell timers restart
        @(posedge clk_150m);
        online   <= '0;
        sta_dval <= '0;
        repeat (4) @(posedge clk_150m);
        card_id       <= field[F_CARD];
        code_version  <= field[F_VER][15:0];
        slot_num      <= field[F_SLOT][3:0];
        sta_num       <= field[F_STA][7:0];
        box_num       <= field[F_BOX][2:0];
        enable_slot   <= field[F_EN][15:0];
        online        <= field[F_ONLINE][15:0];
        chn_slink_err <= field[F_SLINK][15:0];
        cfg_wr_ok     <= field[F_WR_OK][0];
        emif_err      <= field[F_EMIF][0];
        // Strobe once presence has passed the two sync stages
        repeat (3) @(posedge clk_150m);
        sta_dval <= field[F_DVAL][15:0];
        @(posedge clk_150m);
        sta_dval <= '0;
    endtask

    task automatic poll_words();
        reg_data_t word0;
        reg_data_t word1;
        reg_data_t word2;
        int        tries;
        bit        settled;
        tries   = 0;
        settled = 1'b0;
        while (!settled && tries < POLL_TRIES) begin
            read_word(ADDR_CFG, word0);
            read_word(ADDR_SLINK, word1);
            read_word(ADDR_ENABLE, word2);
            settled = (word0 === field[F_EXP0][15:0]) &&
                      (word1 === field[F_EXP1][15:0]) &&
                      (word2 === field[F_EXP2][15:0]);
            tries++;
        end
        if (!settled) begin
            $display("Test %0h: register words did not settle within three check periods",
                     field[F_TEST]);
            test_errors++;
        end
        compare_word("rd_data addr 0", field[F_EXP0][15:0], word0);
        compare_word("rd_data addr 1", field[F_EXP1][15:0], word1);
        compare_word("rd_data addr 2", field[F_EXP2][15:0], word2);
    endtask

    // Unmapped addresses, idle read data and the summary error
    task automatic check_quiet_reads(input logic exp_self_err);
        reg_data_t value;
        read_word(9'd3, value);
        compare_word("rd_data addr 3", 16'h0000, value);
        read_word(9'h1ff, value);
        compare_word("rd_data addr 1ff", 16'h0000, value);
        // Mapped word right before the idle cycle
        read_word(ADDR_CFG, value);
        compare_word("rd_data addr 0", field[F_EXP0][15:0], value);
        @(negedge clk_150m);
        compare_word("rd_data idle", 16'h0000, rd_data);
        compare_word("self_cfg_err", {15'h0000, exp_self_err}, {15'h0000, self_cfg_err});
    endtask

    task automatic run_test();
        logic exp_self_err;
        test_errors = 0;
        apply_pattern();
        poll_words();
        exp_self_err = (field[F_EXP0][6:0] != 7'h00);
        check_quiet_reads(exp_self_err);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0h passed", field[F_TEST]);
        end else begin
            $display("Test %0h failed with %0d errors", field[F_TEST], test_errors);
            tests_failed++;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int    fd;
        int    code;
        string line;
        rst_150m      <= 1'b0;
        rd_sel        <= 1'b0;
        rd_addr       <= '0;
        card_id       <= '0;
        code_version  <= '0;
        enable_slot   <= '0;
        slot_num      <= '0;
        sta_num       <= '0;
        box_num       <= '0;
        emif_err      <= 1'b0;
        cfg_wr_ok     <= 1'b0;
        online        <= '0;
        sta_dval      <= '0;
        chn_slink_err <= '0;
        repeat (3) @(posedge clk_150m);
        rst_150m <= 1'b1;

        fd = $fopen("mpu_case_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file mpu_case_patterns.txt");
            setup_errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               field[0], field[1], field[2], field[3], field[4],
                               field[5], field[6], field[7], field[8], field[9],
                               field[10], field[11], field[12], field[13], field[14]);
                if (code != NUM_FIELDS) begin
                    $display("Pattern line has the wrong number of columns: %s", line);
                    setup_errors++;
                end else begin
                    run_test();
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("Summary: %0d run, %0d failed, %0d setup errors",
                 tests_run, tests_failed, setup_errors);
        if (tests_failed == 0 && setup_errors == 0 && tests_run > 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== mpu_case_patterns.txt ====
# test card_id version slot sta box enable online dval slink wr_ok emif
# then expected read words at address 0, 1 and 2, all hex
1 00141A43 0100 3 1A 2 0000 0000 0000 0000 1 0 0080 0000 0000
2 00141A43 0100 4 1A 2 0000 0000 0000 0000 1 0 0090 0000 0000
3 00141A43 0100 3 1A 3 0000 0000 0000 0000 1 0 00A0 0000 0000
4 00141A43 0100 3 1B 2 0000 0000 0000 0000 1 0 00C0 0000 0000
5 00181A43 0100 3 1A 2 0000 0000 0000 0000 1 0 0082 0000 0000
6 00141A43 0101 3 1A 2 0000 0000 0000 0000 1 0 0088 0000 0000
7 00141A43 0100 3 1A 2 0000 0000 0000 0000 0 0 0000 0000 0000
8 00141A43 0200 4 1A 2 0000 0000 0000 0000 0 0 0018 0000 0000
9 00141A43 0100 3 1A 2 0007 0015 0011 0000 1 0 0080 0000 0016
10 00141A43 0100 3 1A 2 FFFF FFFF FFFF 0000 1 0 0080 0000 0000
11 00141A43 0100 3 1A 2 FF00 0F0F 0F0F 0000 1 0 0080 0000 F00F
12 00141A43 0100 3 1A 2 00FF 0000 0000 0F3C 1 0 0080 3C00 00FF
13 00141A43 0100 3 1A 2 FF0F 0000 0000 A5A5 1 0 0080 05A5 FF0F
14 00141A43 0100 3 1A 2 0000 0000 0000 0000 1 1 0180 0000 0000
15 00141A43 0100 3 1A 2 0000 0000 0000 0000 1 0 0080 0000 0000

// ==== flist.f ====
mpu_case_pkg.sv
case_sync_if.sv
case_input_sync.sv
cfg_check.sv
slot_monitor.sv
status_regfile.sv
mpu_case_status.sv
mpu_case_checker.sv
tb_mpu_case_status.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_mpu_case_status
FLIST     := flist.f

SOURCES   := $(shell grep -v '^+' $(FLIST))
BINARY    := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BINARY)
	./$(BINARY) > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
